// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_exec_core
FILELIST  = exec_core.f
OBJ_DIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: exec_alu.sv
`timescale 1ns/100ps

module exec_alu
    import exec_pkg::*;
(
    input  alu_op_t  alu_op,
    input  br_cond_t br_cond,
    input  xlen_t    src_a,
    input  xlen_t    src_b,
    input  xlen_t    cmp_a,
    input  xlen_t    cmp_b,
    output xlen_t    result,
    output logic     cond_true
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = src_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = src_a + src_b;
            ALU_SUB:    result = src_a - src_b;
            ALU_SLL:    result = src_a << shamt;
            ALU_SLT:    result = {31'd0, $signed(src_a) < $signed(src_b)};
            ALU_SLTU:   result = {31'd0, src_a < src_b};
            ALU_XOR:    result = src_a ^ src_b;
            ALU_SRL:    result = src_a >> shamt;
            ALU_SRA:    result = $signed(src_a) >>> shamt;
            ALU_OR:     result = src_a | src_b;
            ALU_AND:    result = src_a & src_b;
            ALU_PASS_B: result = src_b;
            default:    result = '0;
        endcase
    end

    // compare side works on the register operands only
    assign eq   = (cmp_a == cmp_b);
    assign lt_s = ($signed(cmp_a) < $signed(cmp_b));
    assign lt_u = (cmp_a < cmp_b);

    always_comb begin
        case (br_cond)
            BR_NONE:   cond_true = 1'b0;
            BR_ALWAYS: cond_true = 1'b1;    // jal, jalr
            BR_EQ:     cond_true = eq;
            BR_NE:     cond_true = !eq;
            BR_LT:     cond_true = lt_s;
            BR_GE:     cond_true = !lt_s;
            BR_LTU:    cond_true = lt_u;
            BR_GEU:    cond_true = !lt_u;
            default:   cond_true = 1'b0;
        endcase
    end

endmodule

// File: exec_bypass.sv
`timescale 1ns/100ps

module exec_bypass
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  logic     push_we,
    input  reg_idx_t push_rd,
    input  xlen_t    push_data,
    input  logic     push_load,
    input  logic     fill_en,
    input  xlen_t    fill_data,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  xlen_t    reg1,
    input  xlen_t    reg2,
    output xlen_t    src1,
    output xlen_t    src2,
    output logic     wait1,
    output logic     wait2
);

    // entry 0 is the newest
    logic [BYPASS_DEPTH-1:0] hist_valid;
    logic [BYPASS_DEPTH-1:0] hist_pend;
    reg_idx_t                hist_rd   [BYPASS_DEPTH];
    xlen_t                   hist_data [BYPASS_DEPTH];

    // history after this cycle's load fill, before the shift
    logic [BYPASS_DEPTH-1:0] pend_f;
    xlen_t                   data_f [BYPASS_DEPTH];
    logic                    ins_valid;

    assign ins_valid = push_we && (push_rd != '0);   // x0 never enters

    always_comb begin
        for (int i = 0; i < BYPASS_DEPTH; i++) begin
            if (fill_en && hist_valid[i] && hist_pend[i]) begin
                data_f[i] = fill_data;
            end else begin
                data_f[i] = hist_data[i];
            end
            pend_f[i] = hist_pend[i] && !fill_en;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_valid <= '0;
            hist_pend  <= '0;
        end else if (push) begin
            hist_valid <= {hist_valid[BYPASS_DEPTH-2:0], ins_valid};
            hist_pend  <= {pend_f[BYPASS_DEPTH-2:0], ins_valid && push_load};
        end else begin
            hist_pend  <= pend_f;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 1; i < BYPASS_DEPTH; i++) begin
                hist_rd[i]   <= hist_rd[i-1];
                hist_data[i] <= data_f[i-1];
            end
            hist_rd[0]   <= push_rd;
            hist_data[0] <= push_data;
        end else begin
            hist_data <= data_f;
        end
    end

    // walk oldest to newest so the newest match wins
    function automatic void lookup(input reg_idx_t rs, input xlen_t rf_val,
                                   output xlen_t val, output logic pend);
        val  = rf_val;
        pend = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (hist_valid[i] && (hist_rd[i] == rs) && (rs != '0)) begin
                val  = hist_data[i];
                pend = hist_pend[i];
            end
        end
    endfunction

    always_comb begin
        lookup(rs1, reg1, src1, wait1);
        lookup(rs2, reg2, src2, wait2);
    end

endmodule

// File: exec_core.f
exec_pkg.sv
gpr_file.sv
exec_alu.sv
exec_bypass.sv
exec_unit.sv
exec_core.sv
tb_exec_core.sv

// File: exec_core.sv
`timescale 1ns/100ps

module exec_core
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     idu_valid,
    input  xlen_t    pc,
    input  xlen_t    imm,
    input  reg_idx_t rd,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  logic     gpr_we,
    input  alu_op_t  alu_op,
    input  br_cond_t br_cond,
    input  logic     src1_is_pc,
    input  logic     src2_is_imm,
    input  logic     inst_l,
    input  logic     inst_s,
    input  csr_op_t  csr_op,
    input  xlen_t    csr_data,
    input  logic     ecall_en,
    input  logic     mret_en,
    input  logic     lsu_ready,
    input  xlen_t    rdata_processed,
    input  logic     wb_we,
    input  reg_idx_t wb_rd,
    input  xlen_t    wb_data,
    input  logic     pc_update,
    output logic     exu_ready,
    output logic     exu_valid,
    output xlen_t    ex_result,
    output xlen_t    ex_store_data,
    output xlen_t    ex_csr_wdata,
    output reg_idx_t ex_rd,
    output logic     ex_gpr_we,
    output logic     ex_is_load,
    output logic     ex_is_store,
    output logic     exu_dnpc_valid,
    output xlen_t    exu_dnpc
);

    xlen_t src1_r;
    xlen_t src2_r;

    gpr_file u_gpr (
        .clk    (clk),
        .rst    (rst),
        .we     (wb_we),
        .waddr  (wb_rd),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (src1_r),
        .rdata2 (src2_r)
    );

    exec_unit u_exu (
        .clk             (clk),
        .rst             (rst),
        .idu_valid       (idu_valid),
        .lsu_ready       (lsu_ready),
        .rdata_processed (rdata_processed),
        .pc              (pc),
        .imm             (imm),
        .rd              (rd),
        .rs1             (rs1),
        .rs2             (rs2),
        .src1_r          (src1_r),
        .src2_r          (src2_r),
        .gpr_we          (gpr_we),
        .alu_op          (alu_op),
        .br_cond         (br_cond),
        .src1_is_pc      (src1_is_pc),
        .src2_is_imm     (src2_is_imm),
        .inst_l          (inst_l),
        .inst_s          (inst_s),
        .csr_op          (csr_op),
        .csr_data        (csr_data),
        .ecall_en        (ecall_en),
        .mret_en         (mret_en),
        .pc_update       (pc_update),
        .exu_ready       (exu_ready),
        .exu_valid       (exu_valid),
        .ex_result       (ex_result),
        .ex_store_data   (ex_store_data),
        .ex_csr_wdata    (ex_csr_wdata),
        .ex_rd           (ex_rd),
        .ex_gpr_we       (ex_gpr_we),
        .ex_is_load      (ex_is_load),
        .ex_is_store     (ex_is_store),
        .exu_dnpc_valid  (exu_dnpc_valid),
        .exu_dnpc        (exu_dnpc)
    );

endmodule

// File: exec_pkg.sv
package exec_pkg;

    localparam int XLEN         = 32;
    localparam int REG_IDX_W    = 4;    // rv32e, 16 registers
    localparam int NUM_REGS     = 16;
    localparam int BYPASS_DEPTH = 4;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // main alu operation
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10     // lui
    } alu_op_t;

    // condition for a pc change, none means no jump at all
    typedef enum logic [2:0] {
        BR_NONE   = 3'd0,
        BR_ALWAYS = 3'd1,
        BR_EQ     = 3'd2,
        BR_NE     = 3'd3,
        BR_LT     = 3'd4,
        BR_GE     = 3'd5,
        BR_LTU    = 3'd6,
        BR_GEU    = 3'd7
    } br_cond_t;

    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2
    } csr_op_t;

endpackage

// File: exec_unit.sv
`timescale 1ns/100ps

module exec_unit
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     idu_valid,
    input  logic     lsu_ready,
    input  xlen_t    rdata_processed,
    input  xlen_t    pc,
    input  xlen_t    imm,
    input  reg_idx_t rd,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  xlen_t    src1_r,
    input  xlen_t    src2_r,
    input  logic     gpr_we,
    input  alu_op_t  alu_op,
    input  br_cond_t br_cond,
    input  logic     src1_is_pc,
    input  logic     src2_is_imm,
    input  logic     inst_l,
    input  logic     inst_s,
    input  csr_op_t  csr_op,
    input  xlen_t    csr_data,
    input  logic     ecall_en,
    input  logic     mret_en,
    input  logic     pc_update,
    output logic     exu_ready,
    output logic     exu_valid,
    output xlen_t    ex_result,
    output xlen_t    ex_store_data,
    output xlen_t    ex_csr_wdata,
    output reg_idx_t ex_rd,
    output logic     ex_gpr_we,
    output logic     ex_is_load,
    output logic     ex_is_store,
    output logic     exu_dnpc_valid,
    output xlen_t    exu_dnpc
);

    xlen_t src1;
    xlen_t src2;
    logic  wait1;
    logic  wait2;
    xlen_t alu_a;
    xlen_t alu_b;
    xlen_t alu_result;
    logic  cond_true;
    xlen_t pc_plus4;
    xlen_t result;
    xlen_t csr_wdata;
    xlen_t target;
    logic  accept;
    logic  fire;
    logic  trap;
    logic  redirect;

    assign accept    = idu_valid && exu_ready;
    assign fire      = accept && !exu_dnpc_valid;   // squashed while redirect pending
    assign exu_ready = lsu_ready && !wait1 && !wait2;

    assign alu_a    = src1_is_pc ? pc : src1;
    assign alu_b    = src2_is_imm ? imm : src2;
    assign pc_plus4 = pc + 32'd4;

    exec_alu u_alu (
        .alu_op    (alu_op),
        .br_cond   (br_cond),
        .src_a     (alu_a),
        .src_b     (alu_b),
        .cmp_a     (src1),
        .cmp_b     (src2),
        .result    (alu_result),
        .cond_true (cond_true)
    );

    exec_bypass u_bypass (
        .clk       (clk),
        .rst       (rst),
        .push      (fire),
        .push_we   (gpr_we),
        .push_rd   (rd),
        .push_data (result),
        .push_load (inst_l),
        .fill_en   (lsu_ready),
        .fill_data (rdata_processed),
        .rs1       (rs1),
        .rs2       (rs2),
        .reg1      (src1_r),
        .reg2      (src2_r),
        .src1      (src1),
        .src2      (src2),
        .wait1     (wait1),
        .wait2     (wait2)
    );

    // any br_cond other than none is a pc jump, link value is pc+4
    always_comb begin
        if (csr_op != CSR_NONE) begin
            result = csr_data;    // old csr value goes to rd
        end else if (br_cond != BR_NONE) begin
            result = pc_plus4;
        end else begin
            result = alu_result;
        end
    end

    always_comb begin
        case (csr_op)
            CSR_RW:  csr_wdata = src1;
            CSR_RS:  csr_wdata = src1 | csr_data;
            default: csr_wdata = '0;
        endcase
    end

    assign trap     = ecall_en || mret_en;
    assign target   = trap ? csr_data : alu_result;
    assign redirect = (trap || cond_true) && (target != pc_plus4);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exu_valid      <= 1'b0;
            ex_gpr_we      <= 1'b0;
            ex_is_load     <= 1'b0;
            ex_is_store    <= 1'b0;
            exu_dnpc_valid <= 1'b0;
        end else if (exu_ready) begin
            exu_valid   <= fire;
            ex_gpr_we   <= fire && gpr_we;
            ex_is_load  <= fire && inst_l;
            ex_is_store <= fire && inst_s;
            if (exu_dnpc_valid) begin
                if (pc_update) begin
                    exu_dnpc_valid <= 1'b0;
                end
            end else if (idu_valid && redirect) begin
                exu_dnpc_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            ex_result     <= result;
            ex_store_data <= src2;
            ex_csr_wdata  <= csr_wdata;
            ex_rd         <= rd;
            if (redirect) begin
                exu_dnpc <= target;
            end
        end
    end

endmodule

// File: gpr_file.sv
`timescale 1ns/100ps

module gpr_file
    import exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  reg_idx_t waddr,
    input  xlen_t    wdata,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output xlen_t    rdata1,
    output xlen_t    rdata2
);

    xlen_t regs [1:NUM_REGS-1];   // no storage for x0

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // reads are combinational, a write shows up the next cycle
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: tb_exec_core.sv
`timescale 1ns/100ps

module tb_exec_core
    import exec_pkg::*;
();

    localparam int    MAX_CYCLES = 3000;
    localparam xlen_t PC_BASE    = 32'h0000_0100;

    logic     clk;
    logic     rst;
    logic     idu_valid, gpr_we, src1_is_pc, src2_is_imm, inst_l, inst_s;
    logic     ecall_en, mret_en, lsu_ready, wb_we, pc_update;
    xlen_t    pc, imm, csr_data, rdata_processed, wb_data;
    reg_idx_t rd, rs1, rs2, wb_rd;
    alu_op_t  alu_op;
    br_cond_t br_cond;
    csr_op_t  csr_op;
    logic     exu_ready, exu_valid, ex_gpr_we, ex_is_load, ex_is_store, exu_dnpc_valid;
    xlen_t    ex_result, ex_store_data, ex_csr_wdata, exu_dnpc;
    reg_idx_t ex_rd;

    xlen_t model [NUM_REGS];    // register values as the stage should see them
    xlen_t lfsr = 32'haafc;
    logic  lsu_next;            // lsu_ready level applied at the accept edge
    int    cycles = 0;

    exec_core uut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run("timeout, the run did not finish within the cycle limit");
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input xlen_t got, input xlen_t want, input string what);
        if (got !== want) begin
            stop_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, want));
        end
    endtask

    task automatic check_idx(input reg_idx_t got, input reg_idx_t want, input string what);
        if (got !== want) begin
            stop_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, want));
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want) begin
            stop_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, want));
        end
    endtask

    // galois form, taps for x^32+x^22+x^2+x+1
    function automatic xlen_t rand_bits(input int n);
        xlen_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic cond_ref(input br_cond_t c, input xlen_t a, input xlen_t b);
        xlen_t sa;
        xlen_t sb;
        sa = a ^ 32'h8000_0000;    // biased, so unsigned compare acts signed
        sb = b ^ 32'h8000_0000;
        case (c)
            BR_ALWAYS: return 1'b1;
            BR_EQ:     return a == b;
            BR_NE:     return a != b;
            BR_LT:     return sa < sb;
            BR_GE:     return sa >= sb;
            BR_LTU:    return a < b;
            BR_GEU:    return a >= b;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic xlen_t alu_ref(input alu_op_t op, input xlen_t a, input xlen_t b);
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a + ~b + 32'd1;
            ALU_SLL:    return a << b[4:0];
            ALU_SLT:    return {31'd0, cond_ref(BR_LT, a, b)};
            ALU_SLTU:   return {31'd0, cond_ref(BR_LTU, a, b)};
            ALU_XOR:    return a ^ b;
            ALU_SRL:    return a >> b[4:0];
            ALU_SRA:    return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            ALU_OR:     return a | b;
            ALU_AND:    return a & b;
            ALU_PASS_B: return b;
            default:    return '0;
        endcase
    endfunction

    // write-back port, value visible to reads after the second edge
    task automatic set_reg(input reg_idx_t r, input xlen_t v);
        @(posedge clk);
        wb_we   <= 1'b1;
        wb_rd   <= r;
        wb_data <= v;
        @(posedge clk);
        wb_we   <= 1'b0;
        if (r != 4'd0) begin
            model[r] = v;
        end
    endtask

    task automatic clear_inst();
        idu_valid   <= 1'b0;
        pc          <= PC_BASE;
        imm         <= '0;
        rd          <= '0;
        rs1         <= '0;
        rs2         <= '0;
        gpr_we      <= 1'b0;
        alu_op      <= ALU_ADD;
        br_cond     <= BR_NONE;
        src1_is_pc  <= 1'b0;
        src2_is_imm <= 1'b0;
        inst_l      <= 1'b0;
        inst_s      <= 1'b0;
        csr_op      <= CSR_NONE;
        csr_data    <= '0;
        ecall_en    <= 1'b0;
        mret_en     <= 1'b0;
    endtask

    // caller may override more fields in the same time step
    task automatic drive_inst(input alu_op_t op, input reg_idx_t d, input reg_idx_t s1,
                              input reg_idx_t s2, input xlen_t im, input logic use_imm,
                              input logic we);
        @(posedge clk);
        clear_inst();
        idu_valid   <= 1'b1;
        alu_op      <= op;
        rd          <= d;
        rs1         <= s1;
        rs2         <= s2;
        imm         <= im;
        src2_is_imm <= use_imm;
        gpr_we      <= we;
    endtask

    // returns at the falling edge after the accepting edge
    task automatic wait_accept();
        @(negedge clk);
        while (!exu_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        idu_valid <= 1'b0;
        lsu_ready <= lsu_next;
        @(negedge clk);
    endtask

    task automatic run_alu(input alu_op_t op, input reg_idx_t d, input reg_idx_t s1,
                           input reg_idx_t s2, input xlen_t im, input logic use_imm,
                           input logic wb);
        xlen_t want;
        want = alu_ref(op, model[s1], use_imm ? im : model[s2]);
        drive_inst(op, d, s1, s2, im, use_imm, 1'b1);
        wait_accept();
        check_bit(exu_valid, 1'b1, "exu_valid");
        check_word(ex_result, want, "ex_result");
        check_idx(ex_rd, d, "ex_rd");
        check_bit(ex_gpr_we, 1'b1, "ex_gpr_we");
        check_word(ex_store_data, model[s2], "ex_store_data");
        if (d != 4'd0) begin
            model[d] = want;
        end
        if (wb) begin
            set_reg(d, want);
        end
    endtask

    task automatic ack_redirect();
        @(posedge clk);
        pc_update <= 1'b1;
        @(posedge clk);
        pc_update <= 1'b0;
        @(negedge clk);
        check_bit(exu_dnpc_valid, 1'b0, "exu_dnpc_valid after pc_update");
    endtask

    task automatic test_reset();
        repeat (8) begin
            @(negedge clk);
            check_bit(exu_valid, 1'b0, "exu_valid in reset");
            check_bit(exu_dnpc_valid, 1'b0, "exu_dnpc_valid in reset");
        end
        @(posedge clk);
        rst       <= 1'b0;
        lsu_ready <= 1'b0;
        @(negedge clk);
        check_bit(exu_ready, 1'b0, "exu_ready with lsu_ready low");
        check_bit(exu_valid, 1'b0, "idle exu_valid");
        @(posedge clk);
        lsu_ready <= 1'b1;
        @(negedge clk);
        check_bit(exu_ready, 1'b1, "exu_ready with lsu_ready high");
        check_bit(exu_dnpc_valid, 1'b0, "exu_dnpc_valid after reset");
    endtask

    task automatic test_alu();
        alu_op_t op;
        for (int i = 1; i < NUM_REGS; i++) begin
            set_reg(4'(i), rand_bits(32));
        end
        for (int i = 0; i <= 10; i++) begin
            op = alu_op_t'(4'(i));
            run_alu(op, 4'd14, 4'(1 + i % 7), 4'(8 + i % 5), rand_bits(32), 1'b0, 1'b1);
            run_alu(op, 4'd14, 4'(1 + i % 7), 4'(8 + i % 5), rand_bits(32), 1'b1, 1'b1);
        end
    endtask

    task automatic test_forwarding();
        // x10 built from its own last value, several x10 entries live at once
        for (int i = 0; i < 6; i++) begin
            run_alu(ALU_ADD, 4'd10, 4'd10, 4'd0, rand_bits(12), 1'b1, 1'b0);
        end
        run_alu(ALU_PASS_B, 4'd0, 4'd0, 4'd0, rand_bits(32), 1'b1, 1'b0);
        run_alu(ALU_OR, 4'd11, 4'd0, 4'd3, '0, 1'b0, 1'b0);
        run_alu(ALU_SUB, 4'd12, 4'd10, 4'd11, '0, 1'b0, 1'b0);
        set_reg(4'd10, model[10]);
        set_reg(4'd11, model[11]);
        set_reg(4'd12, model[12]);
    endtask

    task automatic test_load_use();
        xlen_t word;
        word     = rand_bits(32);
        lsu_next = 1'b0;
        drive_inst(ALU_ADD, 4'd5, 4'd2, 4'd0, 32'h10, 1'b1, 1'b1);
        inst_l <= 1'b1;
        wait_accept();
        lsu_next = 1'b1;
        check_bit(ex_is_load, 1'b1, "ex_is_load on load");
        check_bit(ex_is_store, 1'b0, "ex_is_store on load");
        check_word(ex_result, alu_ref(ALU_ADD, model[2], 32'h10), "load address");
        repeat (2) @(negedge clk);
        check_bit(exu_valid, 1'b1, "exu_valid held with lsu_ready low");
        drive_inst(ALU_ADD, 4'd6, 4'd5, 4'd0, 32'd3, 1'b1, 1'b1);
        repeat (3) begin
            @(negedge clk);
            check_bit(exu_ready, 1'b0, "exu_ready on load-use");
        end
        @(posedge clk);
        lsu_ready       <= 1'b1;
        rdata_processed <= word;
        @(negedge clk);
        check_bit(exu_ready, 1'b0, "exu_ready before fill");
        @(posedge clk);
        lsu_ready <= 1'b0;
        @(negedge clk);
        check_bit(exu_ready, 1'b0, "exu_ready after fill, lsu_ready low");
        @(posedge clk);
        lsu_ready <= 1'b1;
        wait_accept();
        check_word(ex_result, word + 32'd3, "load-use result");
        set_reg(4'd5, word);
        set_reg(4'd6, word + 32'd3);
        drive_inst(ALU_ADD, 4'd0, 4'd2, 4'd3, 32'h8, 1'b1, 1'b0);
        inst_s <= 1'b1;
        wait_accept();
        check_bit(exu_valid, 1'b1, "exu_valid on store");
        check_bit(ex_is_store, 1'b1, "ex_is_store on store");
        check_bit(ex_is_load, 1'b0, "ex_is_load on store");
        check_bit(ex_gpr_we, 1'b0, "ex_gpr_we on store");
        check_word(ex_store_data, model[3], "store data");
    endtask

    task automatic test_branch();
        reg_idx_t s2;
        logic     taken;
        drive_inst(ALU_ADD, 4'd1, 4'd0, 4'd0, 32'h40, 1'b1, 1'b1);
        br_cond    <= BR_ALWAYS;
        src1_is_pc <= 1'b1;
        wait_accept();
        check_word(ex_result, PC_BASE + 32'd4, "jal link value");
        check_bit(exu_dnpc_valid, 1'b1, "jal redirect");
        check_word(exu_dnpc, alu_ref(ALU_ADD, PC_BASE, 32'h40), "jal target");
        // in the shadow of the jump
        drive_inst(ALU_PASS_B, 4'd7, 4'd0, 4'd0, 32'hdead_0007, 1'b1, 1'b1);
        wait_accept();
        check_bit(exu_valid, 1'b0, "squashed exu_valid");
        check_bit(ex_gpr_we, 1'b0, "squashed ex_gpr_we");
        ack_redirect();
        set_reg(4'd1, PC_BASE + 32'd4);
        run_alu(ALU_ADD, 4'd12, 4'd7, 4'd0, '0, 1'b1, 1'b1);
        drive_inst(ALU_ADD, 4'd0, 4'd0, 4'd0, 32'd4, 1'b1, 1'b0);
        br_cond    <= BR_ALWAYS;
        src1_is_pc <= 1'b1;
        wait_accept();
        check_word(ex_result, PC_BASE + 32'd4, "jump to pc+4 link value");
        check_bit(exu_dnpc_valid, 1'b0, "redirect for target pc+4");
        for (int c = 2; c < 8; c++) begin
            for (int k = 0; k < 2; k++) begin
                s2    = (k == 0) ? 4'd2 : 4'd3;    // equal, then different operands
                taken = cond_ref(br_cond_t'(3'(c)), model[2], model[s2]);
                drive_inst(ALU_ADD, 4'd0, 4'd2, s2, 32'h20, 1'b1, 1'b0);
                br_cond    <= br_cond_t'(3'(c));
                src1_is_pc <= 1'b1;
                wait_accept();
                check_word(ex_result, PC_BASE + 32'd4, "branch link value");
                check_bit(exu_dnpc_valid, taken, "branch redirect");
                if (taken) begin
                    check_word(exu_dnpc, alu_ref(ALU_ADD, PC_BASE, 32'h20), "branch target");
                    ack_redirect();
                end
            end
        end
    endtask

    task automatic test_csr();
        xlen_t old;
        for (int k = 0; k < 2; k++) begin
            old = rand_bits(32);
            drive_inst(ALU_ADD, 4'd6, 4'd4, 4'd0, '0, 1'b0, 1'b1);
            csr_op   <= (k == 0) ? CSR_RW : CSR_RS;
            csr_data <= old;
            wait_accept();
            check_word(ex_result, old, "csr old value to rd");
            check_word(ex_csr_wdata, (k == 0) ? model[4] : (model[4] | old), "csr write value");
            set_reg(4'd6, old);
        end
        // ecall, then mret
        for (int k = 0; k < 2; k++) begin
            old = rand_bits(30) << 2;
            drive_inst(ALU_ADD, 4'd0, 4'd0, 4'd0, '0, 1'b0, 1'b0);
            ecall_en <= (k == 0);
            mret_en  <= (k == 1);
            csr_data <= old;
            wait_accept();
            check_bit(exu_dnpc_valid, 1'b1, "trap redirect");
            check_word(exu_dnpc, old, "trap target");
            ack_redirect();
        end
    endtask

    initial begin
        clk             = 1'b0;
        rst             <= 1'b1;
        lsu_ready       <= 1'b1;
        rdata_processed <= '0;
        wb_we           <= 1'b0;
        wb_rd           <= '0;
        wb_data         <= '0;
        pc_update       <= 1'b0;
        lsu_next        = 1'b1;
        clear_inst();
        for (int i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
        end
        test_reset();
        test_alu();
        test_forwarding();
        test_load_use();
        test_branch();
        test_csr();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
